//--- vlog.f
src/alu_pkg.sv
src/operand_select.sv
src/arith_unit.sv
src/bitwise_unit.sv
src/result_register.sv
src/alu_top.sv
testbench/alu_properties.sv
testbench/alu_tb.sv

//--- testbench/alu_tb.sv
`default_nettype none

module alu_tb
  import alu_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 4;

  typedef struct packed {
    logic [5:0]  op;
    logic [15:0] acc;
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] imm;
    logic        ra;
    logic        chain;      // next entry strobes on the following cycle
    logic [15:0] exp_res;
    logic [3:0]  exp_flags;  // zero neg carry ovf
  } vector_t;

  logic     clk;
  logic     rst;
  logic     en;
  alu_req_t req;
  data_t    res;
  flags_t   flags;
  logic     done;

  vector_t vectors[$];
  logic    table_ready = 1'b0;
  int      errors = 0;
  int      checks = 0;

  alu_top alu_top_inst (
    .clk   (clk),
    .rst   (rst),
    .en    (en),
    .req   (req),
    .res   (res),
    .flags (flags),
    .done  (done)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic add_vector(input logic [5:0] op, input logic [15:0] acc, input logic [15:0] x,
                            input logic [15:0] y, input logic [15:0] imm, input logic ra,
                            input logic chain, input logic [15:0] exp_res,
                            input logic [3:0] exp_flags);
    vectors.push_back({op, acc, x, y, imm, ra, chain, exp_res, exp_flags});
  endtask

  task automatic build_table();
    add_vector(OP_ADD, 16'h7fff, 16'h0001, 16'h0000, 16'h0000, 1'b0, 1'b1, 16'h8000, 4'b0101);
    add_vector(OP_ADD, 16'h1234, 16'h0000, 16'hffff, 16'h0001, 1'b1, 1'b0, 16'h0000, 4'b1010);
    add_vector(OP_SUB, 16'h0003, 16'h0005, 16'h0000, 16'h0000, 1'b0, 1'b0, 16'hfffe, 4'b0110);
    add_vector(OP_SUB, 16'h0000, 16'h0000, 16'h0064, 16'h0028, 1'b1, 1'b0, 16'h003c, 4'b0000);
    add_vector(OP_SUB, 16'h8000, 16'h0001, 16'h0000, 16'h0000, 1'b0, 1'b0, 16'h7fff, 4'b0001);
    add_vector(OP_CMP, 16'h0005, 16'h0005, 16'h0000, 16'h0000, 1'b0, 1'b0, 16'h7fff, 4'b1000);
    add_vector(OP_CMP, 16'h0000, 16'h0002, 16'h0000, 16'h0007, 1'b0, 1'b0, 16'h7fff, 4'b0110);
    add_vector(OP_INC, 16'h5555, 16'h00ff, 16'h0000, 16'h0000, 1'b0, 1'b0, 16'h0100, 4'b0000);
    add_vector(OP_INC, 16'h0000, 16'h0000, 16'hffff, 16'h0009, 1'b1, 1'b0, 16'h0000, 4'b1010);
    add_vector(OP_DEC, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 1'b0, 1'b0, 16'hffff, 4'b0110);
    add_vector(OP_DEC, 16'h0000, 16'h0000, 16'h8000, 16'h0000, 1'b1, 1'b0, 16'h7fff, 4'b0001);
    add_vector(OP_MUL, 16'h0007, 16'hfffd, 16'h0000, 16'h0000, 1'b0, 1'b0, 16'hffeb, 4'b0100);
    add_vector(OP_MUL, 16'h0000, 16'h0000, 16'h0100, 16'h0100, 1'b1, 1'b0, 16'h0000, 4'b1001);
    add_vector(OP_MUL, 16'h0000, 16'h00b5, 16'h0000, 16'h00b4, 1'b0, 1'b0, 16'h7f44, 4'b0000);
    add_vector(OP_AND, 16'hf0f0, 16'h3c3c, 16'h0000, 16'h0000, 1'b0, 1'b1, 16'h3030, 4'b0000);
    add_vector(OP_OR,  16'h0000, 16'h0000, 16'h1200, 16'h0034, 1'b1, 1'b1, 16'h1234, 4'b0000);
    add_vector(OP_XOR, 16'haaaa, 16'haaaa, 16'h0000, 16'h0000, 1'b0, 1'b0, 16'h0000, 4'b1000);
    add_vector(OP_NOT, 16'h0000, 16'h0000, 16'h00ff, 16'h0000, 1'b1, 1'b0, 16'hff00, 4'b0100);
    add_vector(OP_LSL, 16'h0001, 16'h0004, 16'h0000, 16'h0000, 1'b0, 1'b0, 16'h0010, 4'b0000);
    add_vector(OP_LSL, 16'h0000, 16'h1234, 16'h0000, 16'h0010, 1'b0, 1'b0, 16'h0000, 4'b1000);
    add_vector(OP_LSR, 16'h0000, 16'h8000, 16'h0000, 16'h000f, 1'b0, 1'b0, 16'h0001, 4'b0000);
    add_vector(OP_LSR, 16'hffff, 16'h0100, 16'h0000, 16'h0000, 1'b0, 1'b0, 16'h0000, 4'b1000);
    add_vector(OP_RSR, 16'h0000, 16'h0001, 16'h0000, 16'h0001, 1'b0, 1'b0, 16'h8000, 4'b0100);
    add_vector(6'd18,  16'h0001, 16'h0001, 16'h0000, 16'h0000, 1'b0, 1'b1, 16'h8000, 4'b0100);
    add_vector(OP_RSL, 16'h0000, 16'h0000, 16'h8001, 16'h0011, 1'b1, 1'b0, 16'h0003, 4'b0000);
    add_vector(OP_RSR, 16'h1234, 16'h0004, 16'h0000, 16'h0000, 1'b0, 1'b0, 16'h4123, 4'b0000);
  endtask

  task automatic apply_vector(input vector_t v);
    en         = 1'b1;
    req.opcode = opcode_e'(v.op);
    req.acc    = v.acc;
    req.x      = v.x;
    req.y      = v.y;
    req.imm    = v.imm;
    req.ra     = v.ra;
  endtask

  task automatic check_outputs(input logic exp_done, input logic [15:0] exp_res,
                               input logic [3:0] exp_flags);
    checks += 3;
    if (done !== exp_done) begin
      $display("Error at %0t: done expected %b, got %b", $time, exp_done, done);
      errors++;
    end
    if (res !== exp_res) begin
      $display("Error at %0t: res expected %h, got %h", $time, exp_res, res);
      errors++;
    end
    if (flags !== exp_flags) begin
      $display("Error at %0t: flags expected %b, got %b", $time, exp_flags, flags);
      errors++;
    end
  endtask

  initial begin : watchdog
    wait (table_ready);
    #((vectors.size() * 3 + 40) * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d clock periods",
             vectors.size() * 3 + 40);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : stimulus
    logic    chained;
    int      start_errors;
    vector_t v;

    clk = 1'b0;
    rst = 1'b0;
    en  = 1'b0;
    req = '0;
    build_table();
    table_ready = 1'b1;

    repeat (16) @(posedge clk);
    #1;
    rst = 1'b1;

    // idle cycles after reset with nothing strobed
    start_errors = errors;
    repeat (3) begin
      @(posedge clk);
      #1;
      check_outputs(1'b0, 16'h0000, 4'b0000);
    end
    $display("reset: %s", (errors == start_errors) ? "ok" : "mismatch");

    chained = 1'b0;
    for (int i = 0; i < vectors.size(); i++) begin
      v = vectors[i];
      start_errors = errors;
      if (!chained) begin
        @(posedge clk);
        #1;
        checks++;
        if (done !== 1'b0) begin
          $display("Error at %0t: done expected 0, got %b", $time, done);
          errors++;
        end
      end
      apply_vector(v);
      @(posedge clk);
      #1;
      check_outputs(1'b1, v.exp_res, v.exp_flags);
      chained = v.chain;
      if (!chained) begin
        en = 1'b0;
      end
      $display("entry %0d opcode %0d: %s", i, v.op, (errors == start_errors) ? "ok" : "mismatch");
    end

    $display("%0d entries, %0d checks, %0d errors", vectors.size(), checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/alu_properties.sv
`default_nettype none

module alu_properties
  import alu_pkg::*;
(
  input logic         clk,
  input logic         rst,
  input logic         en,
  input unit_result_t arith,
  input unit_result_t bits,
  input data_t        res,
  input flags_t       flags,
  input logic         done
);
  timeunit 1ns;
  timeprecision 100ps;

  logic unit_write;

  assign unit_write = (arith.hit && arith.write_res) || (bits.hit && bits.write_res);

  done_low_in_reset: assert property (@(posedge clk) !rst |=> !done)
    else $error("done high after a reset cycle");

  done_follows_en: assert property (@(posedge clk) $past(rst) |-> (done == $past(en)))
    else $error("done does not follow the previous strobe");

  zero_matches_res: assert property (@(posedge clk)
    (rst && en && unit_write) |=> (flags.zero == (res == '0)))
    else $error("zero flag disagrees with the written result");

endmodule

bind result_register alu_properties alu_properties_inst (.*);

`default_nettype wire

//--- src/alu_top.sv
`default_nettype none

module alu_top
  import alu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     en,
  input  alu_req_t req,
  output data_t    res,
  output flags_t   flags,
  output logic     done
);

  operands_t    ops;
  unit_result_t arith;
  unit_result_t bits;

  operand_select operand_select_inst (
    .req (req),
    .ops (ops)
  );

  arith_unit arith_unit_inst (
    .opcode (req.opcode),
    .ops    (ops),
    .arith  (arith)
  );

  bitwise_unit bitwise_unit_inst (
    .opcode (req.opcode),
    .ops    (ops),
    .bits   (bits)
  );

  result_register result_register_inst (
    .clk   (clk),
    .rst   (rst),
    .en    (en),
    .arith (arith),
    .bits  (bits),
    .res   (res),
    .flags (flags),
    .done  (done)
  );

endmodule

`default_nettype wire

//--- src/result_register.sv
`default_nettype none

module result_register
  import alu_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         en,
  input  unit_result_t arith,
  input  unit_result_t bits,
  output data_t        res,
  output flags_t       flags,
  output logic         done
);

  unit_result_t sel;
  logic         any_hit;
  flags_t       next_flags;
  logic         flag_we;
  logic         res_we;

  // units never hit together
  assign sel     = arith.hit ? arith : bits;
  assign any_hit = arith.hit | bits.hit;

  always_comb begin
    next_flags.zero  = (sel.value == '0);
    next_flags.neg   = sel.value[DATA_W-1];
    next_flags.carry = sel.carry;
    next_flags.ovf   = sel.ovf;
  end

  assign flag_we = en && any_hit;  // unknown opcode keeps state
  assign res_we  = flag_we && sel.write_res;

  always_ff @(posedge clk) begin
    if (!rst) begin
      res   <= '0;
      flags <= '0;
      done  <= 1'b0;
    end else begin
      done <= en;  // every strobe answered
      if (flag_we) begin
        flags <= next_flags;
      end
      if (res_we) begin
        res <= sel.value;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/bitwise_unit.sv
`default_nettype none

module bitwise_unit
  import alu_pkg::*;
(
  input  opcode_e      opcode,
  input  operands_t    ops,
  output unit_result_t bits
);

  logic [DATA_W-1:0]   a_bits;
  logic [DATA_W-1:0]   b_bits;
  logic                shift_big;
  logic [SHAMT_W-1:0]  amt;
  logic [DATA_W-1:0]   shl;
  logic [DATA_W-1:0]   shr;
  logic [2*DATA_W-1:0] rot_dbl;
  logic [2*DATA_W-1:0] rot_r;
  logic [2*DATA_W-1:0] rot_l;

  assign a_bits = ops.a;
  assign b_bits = ops.b;
  assign amt    = b_bits[SHAMT_W-1:0];

  // any count of DATA_W or more shifts everything out
  assign shift_big = (b_bits[DATA_W-1:SHAMT_W] != '0);
  assign shl = shift_big ? '0 : (a_bits << amt);
  assign shr = shift_big ? '0 : (a_bits >> amt);

  // barrel rotate on a doubled word by count mod DATA_W
  assign rot_dbl = {a_bits, a_bits};
  assign rot_r   = rot_dbl >> amt;
  assign rot_l   = rot_dbl << amt;

  always_comb begin
    bits.hit       = 1'b1;
    bits.write_res = 1'b1;
    bits.carry     = 1'b0;
    bits.ovf       = 1'b0;
    case (opcode)
      OP_AND:  bits.value = a_bits & b_bits;
      OP_OR:   bits.value = a_bits | b_bits;
      OP_XOR:  bits.value = a_bits ^ b_bits;
      OP_NOT:  bits.value = ~a_bits;
      OP_LSL:  bits.value = shl;
      OP_LSR:  bits.value = shr;
      OP_RSR:  bits.value = rot_r[DATA_W-1:0];
      OP_RSL:  bits.value = rot_l[2*DATA_W-1:DATA_W];
      default: begin
        bits.hit       = 1'b0;  // not ours
        bits.write_res = 1'b0;
        bits.value     = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/arith_unit.sv
`default_nettype none

module arith_unit
  import alu_pkg::*;
(
  input  opcode_e      opcode,
  input  operands_t    ops,
  output unit_result_t arith
);

  data_t                      op_a;
  data_t                      op_b;
  logic                       is_add;
  logic                       is_sub;
  logic                       is_mul;
  logic [DATA_W-1:0]          b_path;
  logic [DATA_W:0]            sum;
  logic                       add_ovf;
  logic signed [2*DATA_W-1:0] prod;
  logic                       mul_ovf;

  assign op_a = ops.a;
  assign op_b = ops.b;

  always_comb begin
    is_add = 1'b0;
    is_sub = 1'b0;
    is_mul = 1'b0;
    case (opcode)
      OP_ADD,
      OP_INC:  is_add = 1'b1;
      OP_SUB,
      OP_CMP,
      OP_DEC:  is_sub = 1'b1;
      OP_MUL:  is_mul = 1'b1;
      default: ;
    endcase
  end

  // subtract as a + ~b + 1 on the one adder
  assign b_path = is_sub ? ~op_b : op_b;
  assign sum = {1'b0, op_a} + {1'b0, b_path} + {{DATA_W{1'b0}}, is_sub};

  // operands agree in sign but result does not
  assign add_ovf = (op_a[DATA_W-1] == b_path[DATA_W-1]) &&
                   (sum[DATA_W-1] != op_a[DATA_W-1]);

  assign prod = op_a * op_b;

  // upper half plus sign bit of low half must all match
  assign mul_ovf = (prod[2*DATA_W-1:DATA_W-1] != '0) &&
                   (prod[2*DATA_W-1:DATA_W-1] != '1);

  always_comb begin
    arith.hit       = is_add | is_sub | is_mul;
    arith.write_res = arith.hit && (opcode != OP_CMP);
    arith.value     = '0;
    arith.carry     = 1'b0;
    arith.ovf       = 1'b0;
    if (is_mul) begin
      arith.value = prod[DATA_W-1:0];
      arith.ovf   = mul_ovf;  // carry stays clear
    end else if (is_add || is_sub) begin
      arith.value = sum[DATA_W-1:0];
      arith.carry = is_sub ? ~sum[DATA_W] : sum[DATA_W];  // borrow when a < b
      arith.ovf   = add_ovf;
    end
  end

endmodule

`default_nettype wire

//--- src/operand_select.sv
`default_nettype none

module operand_select
  import alu_pkg::*;
(
  input  alu_req_t  req,
  output operands_t ops
);

  data_t reg_word;
  logic  imm_zero;
  logic  unary_op;

  assign reg_word = req.ra ? req.y : req.x;
  assign imm_zero = (req.imm == '0);

  // single operand ops work on the register word
  always_comb begin
    case (req.opcode)
      OP_INC,
      OP_DEC,
      OP_NOT:  unary_op = 1'b1;
      default: unary_op = 1'b0;
    endcase
  end

  always_comb begin
    if (unary_op) begin
      ops.a = reg_word;
      ops.b = data_t'(1);
    end else if (imm_zero) begin
      ops.a = req.acc;  // acc against register
      ops.b = reg_word;
    end else begin
      ops.a = reg_word;  // register against immediate
      ops.b = req.imm;
    end
  end

endmodule

`default_nettype wire

//--- src/alu_pkg.sv
`default_nettype none

package alu_pkg;

  localparam int DATA_W  = 16;
  localparam int SHAMT_W = 4;  // rotate count bits that matter
  localparam int OP_W    = 6;

  // opcode encoding of the instruction set
  typedef enum logic [OP_W-1:0] {
    OP_ADD = 6'd13,
    OP_SUB = 6'd14,
    OP_LSR = 6'd15,
    OP_LSL = 6'd16,
    OP_MUL = 6'd17,
    OP_CMP = 6'd20,  // flags only
    OP_INC = 6'd21,
    OP_DEC = 6'd22,
    OP_AND = 6'd23,
    OP_OR  = 6'd24,
    OP_XOR = 6'd25,
    OP_NOT = 6'd26,
    OP_RSR = 6'd27,  // rotate right
    OP_RSL = 6'd28   // rotate left
  } opcode_e;

  typedef logic signed [DATA_W-1:0] data_t;

  // bit 3 zero down to bit 0 overflow
  typedef struct packed {
    logic zero;
    logic neg;
    logic carry;
    logic ovf;
  } flags_t;

  typedef struct packed {
    opcode_e opcode;
    data_t   acc;
    data_t   x;
    data_t   y;
    data_t   imm;
    logic    ra;  // 1 selects y
  } alu_req_t;

  typedef struct packed {
    data_t a;
    data_t b;
  } operands_t;

  typedef struct packed {
    logic  hit;        // unit owns the opcode
    logic  write_res;  // low for compare
    data_t value;
    logic  carry;
    logic  ovf;
  } unit_result_t;

endpackage

`default_nettype wire
